/* build.f */
hdl/vj_pkg.sv
hdl/integral_builder.sv
hdl/window_scanner.sv
hdl/haar_feature_stage.sv
hdl/detection_collector.sv
hdl/face_detector.sv
testbench/face_detector_asserts.sv
testbench/face_detector_tb.sv

/* Makefile */
# Verilator build and run for the face detector testbench

TOP := face_detector_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

# the run passes only if the pass line shows up in the output
test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f -o sim
	@out=$$(./obj_dir/sim +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* testbench/face_detector_tb.sv */
// Face detector testbench
`timescale 1ns/1ns

module face_detector_tb;
  import vj_pkg::*;

  localparam int NPIX = IMG_W * IMG_H;
  localparam int MAX_CYCLES = 4 * (NPIX + POSITIONS + 10) + 100;

  logic clock;
  logic reset;
  pixel_t pixel;
  logic pixel_valid;
  logic pixel_last;
  logic pixel_ready;
  logic face_valid;
  face_report_t face;
  logic scan_done;

  pixel_t img [IMG_H][IMG_W];
  face_report_t exp_q [$];
  face_report_t exp_head;
  logic exp_any;
  int exp_cnt;
  int cycles;
  logic [31:0] lfsr;
  string test_name;

  face_detector #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H),
    .WIN(WIN)
  ) u_dut (
    .clock(clock),
    .reset(reset),
    .pixel(pixel),
    .pixel_valid(pixel_valid),
    .pixel_last(pixel_last),
    .pixel_ready(pixel_ready),
    .face_valid(face_valid),
    .face(face),
    .scan_done(scan_done)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic stop_with_failure(input string msg);
    $display("Error in %s: %s", test_name, msg);
    abort_run();
  endtask

  task automatic fail_value(input string what, input int expv, input int actv);
    $display("Fail %s %s expected %h actual %h", test_name, what, expv, actv);
    abort_run();
  endtask

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // galois step
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // 6x6 face with a bright forehead, dark eyes, bright nose, dark mouth row and bright chin
  function automatic pixel_t face_px(input int r, input int c);
    logic mid;
    mid = (c == 2) || (c == 3);
    case (r)
      0, 5: return 8'd200;
      1, 2: return mid ? 8'd200 : 8'd20;
      3: return mid ? 8'd200 : 8'd150;
      default: return 8'd60;
    endcase
  endfunction

  function automatic int rect_sum(input int wr, input int wc, input rect_t rc);
    int s;
    s = 0;
    for (int r = 0; r < int'(rc.h); r++) begin
      for (int c = 0; c < int'(rc.w); c++) begin
        s += int'(img[wr + int'(rc.y) + r][wc + int'(rc.x) + c]);
      end
    end
    return s * int'(rc.weight);
  endfunction

  task automatic fill_image(input logic random_bg, input pixel_t level);
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        img[r][c] = random_bg ? pixel_t'(take_bits(8)) : level;
      end
    end
  endtask

  task automatic paint_face(input int top, input int left);
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        img[top + r][left + c] = face_px(r, c);
      end
    end
  endtask

  // reference cascade on plain pixel sums in raster order with the column fastest
  task automatic build_expected();
    int fv;
    score_t sum;
    logic alive;
    face_report_t rep;
    for (int r = 0; r <= IMG_H - WIN; r++) begin
      for (int c = 0; c <= IMG_W - WIN; c++) begin
        sum = '0;
        alive = 1'b1;
        for (int f = 0; f < NUM_FEATURES; f++) begin
          fv = rect_sum(r, c, FEATURES[f].r0) + rect_sum(r, c, FEATURES[f].r1);
          sum = sum + ((fv > int'(FEATURES[f].thresh)) ? FEATURES[f].above : FEATURES[f].below);
          if (FEATURES[f].stage_end) begin
            alive = alive && (sum > STAGE_THRESH[f]);
            sum = '0;
          end
        end
        if (alive) begin
          rep.row = coord_t'(r);
          rep.col = coord_t'(c);
          exp_q.push_back(rep);
        end
      end
    end
  endtask

  // stream one image and offer junk while the core is busy scanning
  task automatic run_image(input string name);
    logic accepted;
    logic done;
    test_name = name;
    build_expected();
    for (int i = 0; i < NPIX; i++) begin
      pixel = img[i / IMG_W][i % IMG_W];
      pixel_valid = 1'b1;
      pixel_last = (i == NPIX - 1);
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clock);
        accepted = pixel_ready;
        @(posedge clock);
        #1;
      end
    end
    done = 1'b0;
    while (!done) begin
      pixel = pixel_t'(take_bits(8));
      pixel_last = (take_bits(1) != 0);
      @(negedge clock);
      done = scan_done;
      @(posedge clock);
      #1;
    end
    pixel_valid = 1'b0; // withdrawn before the core reopens
    pixel_last = 1'b0;
    repeat (2) @(posedge clock);
    #1;
  endtask

  // expected queue head lagging one cycle behind every push and pop
  always @(posedge clock) begin
    if (face_valid && exp_q.size() > 0) void'(exp_q.pop_front());
    exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    exp_any <= (exp_q.size() > 0);
    exp_cnt <= exp_q.size();
  end

  a_report: assert property (@(posedge clock) disable iff (reset)
      face_valid |-> exp_any && (face == exp_head))
    else begin
      if (!$sampled(exp_any)) stop_with_failure("face report arrived with none expected");
      else fail_value("face row/col", int'($sampled(exp_head)), int'($sampled(face)));
    end

  a_count: assert property (@(posedge clock) disable iff (reset)
      scan_done |-> exp_cnt == (face_valid ? 1 : 0))
    else fail_value("reports left at scan end", $sampled(face_valid) ? 1 : 0, $sampled(exp_cnt));

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) stop_with_failure("timeout, the run did not finish");
    else if (u_dut.u_asserts.fail_count != 0) stop_with_failure("a protocol assertion failed");
  end

  initial begin
    cycles = 0;
    lfsr = 32'h146fc12f;
    test_name = "reset";
    reset = 1'b1;
    pixel = '0;
    pixel_valid = 1'b0;
    pixel_last = 1'b0;
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
    repeat (2) @(posedge clock);
    #1;
    fill_image(1'b1, 8'd0);
    paint_face(2, 3);
    run_image("face");
    fill_image(1'b0, 8'd90);
    run_image("flat");
    fill_image(1'b1, 8'd0);
    paint_face(5, 1);
    run_image("after junk");
    fill_image(1'b1, 8'd0);
    run_image("random");
    repeat (3) @(posedge clock);
    if (u_dut.u_asserts.fail_count == 0 && exp_q.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      stop_with_failure("checks left open at the end of the run");
    end
  end

endmodule

/* testbench/face_detector_asserts.sv */
// Face detector protocol checks
`timescale 1ns/1ns

module face_detector_asserts (
  input logic clock,
  input logic reset,
  input logic pixel_ready,
  input logic load_done,
  input logic face_valid,
  input logic scan_done,
  input vj_pkg::win_token_t win_tok
);
  import vj_pkg::*;

  int unsigned fail_count = 0;
  logic last_issue;
  logic scan_busy;

  assign last_issue = win_tok.valid && (win_tok.row == coord_t'(IMG_H - WIN))
                      && (win_tok.col == coord_t'(IMG_W - WIN));

  // set by load_done, cleared once scan_done has been seen
  always_ff @(posedge clock, posedge reset) begin
    if (reset) scan_busy <= 1'b0;
    else if (load_done) scan_busy <= 1'b1;
    else if (scan_done) scan_busy <= 1'b0;
  end

  // idle core right after reset
  a_reset_state: assert property (@(posedge clock)
      $fell(reset) |-> pixel_ready && !face_valid && !scan_done)
    else begin
      $error("outputs wrong after reset");
      fail_count++;
    end

  a_closed_scan: assert property (@(posedge clock) disable iff (reset)
      (load_done || scan_busy) |-> !pixel_ready)
    else begin
      $error("pixel_ready high between load_done and scan_done");
      fail_count++;
    end

  // scan_done exactly NUM_FEATURES+1 cycles after the last window
  a_done_after: assert property (@(posedge clock) disable iff (reset)
      scan_done |-> $past(last_issue, NUM_FEATURES + 1))
    else begin
      $error("scan_done without a matching last window");
      fail_count++;
    end

  a_done_each: assert property (@(posedge clock) disable iff (reset)
      $past(last_issue, NUM_FEATURES + 1) |-> scan_done)
    else begin
      $error("scan_done missing after the last window");
      fail_count++;
    end

  a_reopen: assert property (@(posedge clock) disable iff (reset)
      scan_done |=> pixel_ready)
    else begin
      $error("pixel_ready not back after scan_done");
      fail_count++;
    end

endmodule

bind face_detector face_detector_asserts u_asserts (
  .clock(clock),
  .reset(reset),
  .pixel_ready(pixel_ready),
  .load_done(load_done),
  .face_valid(face_valid),
  .scan_done(scan_done),
  .win_tok(win_tok)
);

/* hdl/face_detector.sv */
// Face detector top level
`timescale 1ns/1ns

module face_detector #(
  parameter int IMG_W = vj_pkg::IMG_W,
  parameter int IMG_H = vj_pkg::IMG_H,
  parameter int WIN = vj_pkg::WIN
) (
  input  logic clock,
  input  logic reset,
  input  vj_pkg::pixel_t pixel,
  input  logic pixel_valid,
  input  logic pixel_last,
  output logic pixel_ready,
  output logic face_valid,
  output vj_pkg::face_report_t face,
  output logic scan_done
);
  import vj_pkg::*;

  integral_t [IMG_H:0][IMG_W:0] ii;
  logic load_start;
  logic load_done;
  logic drain_done;
  win_token_t win_tok;
  cascade_token_t tok [NUM_FEATURES+1];

  integral_builder #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H)
  ) u_builder (
    .clock(clock),
    .reset(reset),
    .pixel(pixel),
    .pixel_valid(pixel_valid),
    .pixel_last(pixel_last),
    .accept(pixel_ready),
    .load_start(load_start),
    .load_done(load_done),
    .ii(ii)
  );

  window_scanner #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H),
    .WIN(WIN)
  ) u_scanner (
    .clock(clock),
    .reset(reset),
    .load_start(load_start),
    .load_done(load_done),
    .ii(ii),
    .pixel_ready(pixel_ready),
    .drain_done(drain_done),
    .token(win_tok)
  );

  assign tok[0] = '{win: win_tok, sum: '0, alive: 1'b1}; // every window starts alive

  for (genvar i = 0; i < NUM_FEATURES; i++) begin : g_stage
    haar_feature_stage #(
      .FEATURE(i)
    ) u_stage (
      .clock(clock),
      .reset(reset),
      .token_in(tok[i]),
      .token_out(tok[i+1])
    );
  end

  detection_collector u_collector (
    .clock(clock),
    .reset(reset),
    .token_in(tok[NUM_FEATURES]),
    .drain_done(drain_done),
    .face_valid(face_valid),
    .face(face),
    .scan_done(scan_done)
  );

endmodule

/* hdl/detection_collector.sv */
// Detection report collector
`timescale 1ns/1ns

module detection_collector (
  input  logic clock,
  input  logic reset,
  input  vj_pkg::cascade_token_t token_in,
  input  logic drain_done,
  output logic face_valid,
  output vj_pkg::face_report_t face,
  output logic scan_done
);

  logic hit;

  assign hit = token_in.win.valid && token_in.alive; // survived every stage

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      face_valid <= 1'b0;
      scan_done <= 1'b0;
    end else begin
      face_valid <= hit;
      scan_done <= drain_done;
    end
  end

  always_ff @(posedge clock) begin
    if (hit) begin
      face.row <= token_in.win.row;
      face.col <= token_in.win.col;
    end
  end

endmodule

/* hdl/haar_feature_stage.sv */
// Haar feature pipeline stage
`timescale 1ns/1ns

module haar_feature_stage #(
  parameter int FEATURE = 0
) (
  input  logic clock,
  input  logic reset,
  input  vj_pkg::cascade_token_t token_in,
  output vj_pkg::cascade_token_t token_out
);
  import vj_pkg::*;

  localparam feature_t FT = FEATURES[FEATURE];

  logic valid_q;
  cascade_token_t data_q;
  cascade_token_t next_tok;
  int feat_val;
  score_t vote;
  score_t stage_sum;

  // weighted rectangle sum from four integral corners
  function automatic int rect_value(input win_token_t w, input rect_t r);
    int tl;
    int tr;
    int bl;
    int br;
    tl = int'(w.ii[r.y][r.x]);
    tr = int'(w.ii[r.y][r.x + r.w]);
    bl = int'(w.ii[r.y + r.h][r.x]);
    br = int'(w.ii[r.y + r.h][r.x + r.w]);
    return (br + tl - tr - bl) * int'(r.weight);
  endfunction

  always_comb begin
    feat_val = rect_value(token_in.win, FT.r0) + rect_value(token_in.win, FT.r1);
    vote = (feat_val > int'(FT.thresh)) ? FT.above : FT.below;
    stage_sum = token_in.sum + vote;
    next_tok = token_in;
    if (FT.stage_end) begin
      next_tok.alive = token_in.alive && (stage_sum > STAGE_THRESH[FEATURE]);
      next_tok.sum = '0;   // next cascade stage starts fresh
    end else begin
      next_tok.sum = stage_sum;
    end
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) valid_q <= 1'b0;
    else valid_q <= token_in.win.valid;
  end

  always_ff @(posedge clock) begin
    data_q <= next_tok;
  end

  always_comb begin
    token_out = data_q;
    token_out.win.valid = valid_q;
  end

endmodule

/* hdl/window_scanner.sv */
// Window scan controller
`timescale 1ns/1ns

module window_scanner #(
  parameter int IMG_W = vj_pkg::IMG_W,
  parameter int IMG_H = vj_pkg::IMG_H,
  parameter int WIN = vj_pkg::WIN
) (
  input  logic clock,
  input  logic reset,
  input  logic load_start,
  input  logic load_done,
  input  vj_pkg::integral_t [IMG_H:0][IMG_W:0] ii,
  output logic pixel_ready,
  output logic drain_done,
  output vj_pkg::win_token_t token
);
  import vj_pkg::*;

  localparam int DW = $clog2(NUM_FEATURES + 1);

  scan_state_t state_q;
  coord_t row_q;
  coord_t col_q;
  logic [DW-1:0] drain_q;
  logic last_col;
  logic last_pos;

  assign last_col = (col_q == coord_t'(IMG_W - WIN));
  assign last_pos = last_col && (row_q == coord_t'(IMG_H - WIN));

  // closed from load_done on, so no beat slips in before the scan
  assign pixel_ready = (state_q == IDLE) || (state_q == LOAD && !load_done);
  assign drain_done = (state_q == DRAIN) && (drain_q == DW'(NUM_FEATURES - 1));

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state_q <= IDLE;
      row_q <= '0;
      col_q <= '0;
      drain_q <= '0;
    end else begin
      case (state_q)
        IDLE: if (load_start) state_q <= LOAD;
        LOAD: begin
          if (load_done) begin
            state_q <= SCAN;
            row_q <= '0;
            col_q <= '0;
          end
        end
        SCAN: begin
          if (last_pos) begin
            state_q <= DRAIN;
            drain_q <= '0;
          end else if (last_col) begin
            col_q <= '0;
            row_q <= row_q + 1'b1;
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        DRAIN: begin
          if (drain_q == DW'(NUM_FEATURES)) state_q <= IDLE; // pipeline empty
          else drain_q <= drain_q + 1'b1;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // corner block of the current window, one token per cycle in SCAN
  always_comb begin
    token.valid = (state_q == SCAN);
    token.row = row_q;
    token.col = col_q;
    for (int r = 0; r <= WIN; r++) begin
      for (int c = 0; c <= WIN; c++) begin
        token.ii[r][c] = ii[row_q + r][col_q + c];
      end
    end
  end

endmodule

/* hdl/integral_builder.sv */
// Integral image builder
`timescale 1ns/1ns

module integral_builder #(
  parameter int IMG_W = vj_pkg::IMG_W,
  parameter int IMG_H = vj_pkg::IMG_H
) (
  input  logic clock,
  input  logic reset,
  input  vj_pkg::pixel_t pixel,
  input  logic pixel_valid,
  input  logic pixel_last,
  input  logic accept,
  output logic load_start,
  output logic load_done,
  output vj_pkg::integral_t [IMG_H:0][IMG_W:0] ii
);
  import vj_pkg::*;

  integral_t mem [IMG_H][IMG_W]; // values without the zero border
  logic busy;
  logic beat;
  coord_t row_q;
  coord_t col_q;
  coord_t cur_row;
  coord_t cur_col;
  integral_t row_sum_q;
  integral_t row_sum;
  integral_t above;

  assign beat = pixel_valid && accept;
  assign load_start = beat && !busy;   // first beat of a new image

  // position restarts at the origin on the first beat
  assign cur_row = load_start ? '0 : row_q;
  assign cur_col = load_start ? '0 : col_q;

  assign row_sum = ((cur_col == '0) ? '0 : row_sum_q) + integral_t'(pixel);
  assign above = (cur_row == '0) ? '0 : mem[cur_row - 1'b1][cur_col];

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      load_done <= 1'b0;
      row_q <= '0;
      col_q <= '0;
    end else begin
      load_done <= beat && pixel_last;
      if (beat) begin
        busy <= !pixel_last;
        if (cur_col == coord_t'(IMG_W - 1)) begin
          col_q <= '0;
          row_q <= cur_row + 1'b1;
        end else begin
          col_q <= cur_col + 1'b1;
          row_q <= cur_row;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (beat) begin
      row_sum_q <= row_sum;
      mem[cur_row][cur_col] <= row_sum + above;
    end
  end

  for (genvar r = 0; r <= IMG_H; r++) begin : g_row
    for (genvar c = 0; c <= IMG_W; c++) begin : g_col
      if (r == 0 || c == 0) begin : g_zero
        assign ii[r][c] = '0;
      end else begin : g_mem
        assign ii[r][c] = mem[r-1][c-1];
      end
    end
  end

endmodule

/* hdl/vj_pkg.sv */
// Face detector shared definitions
package vj_pkg;

  localparam int IMG_W = 12;
  localparam int IMG_H = 12;
  localparam int WIN = 6;
  localparam int NUM_FEATURES = 4;
  localparam int NUM_STAGES = 2;
  localparam int POSITIONS = (IMG_W - WIN + 1) * (IMG_H - WIN + 1);

  typedef logic [7:0] pixel_t;
  typedef logic [15:0] integral_t;      // 144 * 255 still fits
  typedef logic signed [15:0] score_t;
  typedef logic [3:0] coord_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    SCAN,
    DRAIN
  } scan_state_t;

  // window corners include the row above and the column to the left
  typedef struct packed {
    logic valid;
    coord_t row;
    coord_t col;
    integral_t [WIN:0][WIN:0] ii;
  } win_token_t;

  typedef struct packed {
    win_token_t win;
    score_t sum;
    logic alive;
  } cascade_token_t;

  typedef struct packed {
    coord_t row;
    coord_t col;
  } face_report_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t w;
    coord_t h;
    score_t weight;
  } rect_t;

  typedef struct packed {
    rect_t r0;
    rect_t r1;
    score_t thresh;
    score_t above;
    score_t below;
    logic stage_end;
  } feature_t;

  localparam feature_t FEATURES [NUM_FEATURES] = '{
    // eye band darker than the cheeks
    '{'{4'd0, 4'd1, 4'd6, 4'd2, 16'sd1}, '{4'd0, 4'd3, 4'd6, 4'd2, -16'sd1},
      -16'sd200, 16'sd0, 16'sd3, 1'b0},
    // bright nose bridge between darker sides
    '{'{4'd0, 4'd0, 4'd6, 4'd6, -16'sd1}, '{4'd2, 4'd0, 4'd2, 4'd6, 16'sd3},
      16'sd100, 16'sd2, 16'sd0, 1'b1},
    // mouth darker than chin
    '{'{4'd1, 4'd4, 4'd4, 4'd1, -16'sd1}, '{4'd1, 4'd5, 4'd4, 4'd1, 16'sd1},
      16'sd50, 16'sd2, -16'sd1, 1'b0},
    // forehead brighter than the eyes
    '{'{4'd0, 4'd0, 4'd6, 4'd1, 16'sd1}, '{4'd0, 4'd1, 4'd6, 4'd1, -16'sd1},
      16'sd50, 16'sd2, 16'sd0, 1'b1}
  };

  // only read where the feature closes a cascade stage
  localparam score_t STAGE_THRESH [NUM_FEATURES] = '{16'sd0, 16'sd3, 16'sd0, 16'sd1};

endpackage
